// File: common/vx_pipe_pkg.sv
package vx_pipe_pkg;

	typedef logic [4:0]  reg_idx_t;
	typedef logic [31:0] word_t;

	// Where an in-flight instruction takes its result from
	typedef enum logic [1:0] {
		NO_WB  = 2'd0,
		WB_ALU = 2'd1,
		WB_MEM = 2'd2,
		WB_JAL = 2'd3
	} wb_kind_t;

	localparam reg_idx_t ZERO_REG   = 5'd0;
	localparam word_t    FWD_POISON = 32'hdeadbeef; // Never selected by the latch

	localparam logic STALL    = 1'b1;
	localparam logic NO_STALL = 1'b0;

	// Value a stage will write back, chosen by its kind
	function automatic word_t wb_value(
		wb_kind_t kind,
		word_t    alu,
		word_t    mem,
		word_t    pc_next
	);
		word_t val;
		case (kind)
			WB_JAL:  val = pc_next; // Link address
			WB_MEM:  val = mem;
			default: val = alu;
		endcase
		return val;
	endfunction

endpackage

// File: common/vx_csr_pkg.sv
package vx_csr_pkg;

	typedef logic [11:0] csr_addr_t;

	// mscratch, first register of the scratch bank
	localparam csr_addr_t CSR_BASE = 12'h340;

	// Position of an address inside the scratch bank
	function automatic csr_addr_t csr_offset(csr_addr_t addr);
		return addr - CSR_BASE;
	endfunction

	// Addresses below the base wrap to large offsets and miss
	function automatic logic csr_in_bank(
		csr_addr_t   addr,
		int unsigned count
	);
		return 32'(csr_offset(addr)) < count;
	endfunction

endpackage

// File: hw/vx_regfile.sv
`timescale 1ns/1ps

module vx_regfile (
	input  logic                  clk,
	input  logic                  rst,

	input  vx_pipe_pkg::reg_idx_t rd_idx1,
	input  vx_pipe_pkg::reg_idx_t rd_idx2,
	output vx_pipe_pkg::word_t    rd_data1,
	output vx_pipe_pkg::word_t    rd_data2,

	input  vx_pipe_pkg::reg_idx_t wr_idx,
	input  vx_pipe_pkg::wb_kind_t wr_kind,
	input  vx_pipe_pkg::word_t    wr_alu,
	input  vx_pipe_pkg::word_t    wr_mem,
	input  vx_pipe_pkg::word_t    wr_pc_next
);
	import vx_pipe_pkg::*;

	word_t regs [1:31]; // x0 has no storage
	word_t wr_data;
	logic  wr_en;

	assign wr_data = wb_value(wr_kind, wr_alu, wr_mem, wr_pc_next);
	assign wr_en   = (wr_kind != NO_WB) && (wr_idx != ZERO_REG);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Reads see the old value during a write, forwarding covers that
	assign rd_data1 = (rd_idx1 == ZERO_REG) ? '0 : regs[rd_idx1];
	assign rd_data2 = (rd_idx2 == ZERO_REG) ? '0 : regs[rd_idx2];

endmodule

// File: hw/vx_csr_file.sv
`timescale 1ns/1ps

module vx_csr_file #(
	parameter int CSR_COUNT = 4
) (
	input  logic                   clk,
	input  logic                   rst,

	input  vx_csr_pkg::csr_addr_t  rd_addr,
	output vx_pipe_pkg::word_t     rd_data,

	input  logic                   wr_en,
	input  vx_csr_pkg::csr_addr_t  wr_addr,
	input  vx_pipe_pkg::word_t     wr_data
);
	import vx_pipe_pkg::*;
	import vx_csr_pkg::*;

	localparam int IDX_W = (CSR_COUNT > 1) ? $clog2(CSR_COUNT) : 1;

	word_t            csrs [CSR_COUNT];
	csr_addr_t        rd_off;
	csr_addr_t        wr_off;
	logic [IDX_W-1:0] rd_sel;
	logic [IDX_W-1:0] wr_sel;
	logic             rd_hit;
	logic             wr_hit;

	assign rd_off = csr_offset(rd_addr);
	assign wr_off = csr_offset(wr_addr);
	assign rd_sel = rd_off[IDX_W-1:0];
	assign wr_sel = wr_off[IDX_W-1:0];
	assign rd_hit = csr_in_bank(rd_addr, CSR_COUNT);
	assign wr_hit = csr_in_bank(wr_addr, CSR_COUNT);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < CSR_COUNT; i++) begin
				csrs[i] <= '0;
			end
		end else if (wr_en && wr_hit) begin // Out-of-bank writes dropped
			csrs[wr_sel] <= wr_data;
		end
	end

	assign rd_data = rd_hit ? csrs[rd_sel] : '0;

endmodule

// File: forwarding/vx_forwarding.sv
`timescale 1ns/1ps

module vx_forwarding (
	// Decode
	input  vx_pipe_pkg::reg_idx_t  dec_src1,
	input  vx_pipe_pkg::reg_idx_t  dec_src2,
	input  vx_csr_pkg::csr_addr_t  dec_csr_addr,

	// Execute
	input  vx_pipe_pkg::reg_idx_t  exe_dest,
	input  vx_pipe_pkg::wb_kind_t  exe_wb,
	input  vx_pipe_pkg::word_t     exe_alu_result,
	input  vx_pipe_pkg::word_t     exe_pc_next,
	input  logic                   exe_is_csr,
	input  vx_csr_pkg::csr_addr_t  exe_csr_addr,

	// Memory
	input  vx_pipe_pkg::reg_idx_t  mem_dest,
	input  vx_pipe_pkg::wb_kind_t  mem_wb,
	input  vx_pipe_pkg::word_t     mem_alu_result,
	input  vx_pipe_pkg::word_t     mem_mem_data,
	input  vx_pipe_pkg::word_t     mem_pc_next,
	input  logic                   mem_is_csr,
	input  vx_csr_pkg::csr_addr_t  mem_csr_addr,
	input  vx_pipe_pkg::word_t     mem_csr_result,

	// Writeback
	input  vx_pipe_pkg::reg_idx_t  wb_dest,
	input  vx_pipe_pkg::wb_kind_t  wb_wb,
	input  vx_pipe_pkg::word_t     wb_alu_result,
	input  vx_pipe_pkg::word_t     wb_mem_data,
	input  vx_pipe_pkg::word_t     wb_pc_next,

	output logic                   src1_fwd,
	output logic                   src2_fwd,
	output logic                   csr_fwd,
	output vx_pipe_pkg::word_t     src1_fwd_data,
	output vx_pipe_pkg::word_t     src2_fwd_data,
	output vx_pipe_pkg::word_t     csr_fwd_data,
	output logic                   stall
);
	import vx_pipe_pkg::*;

	logic  src1_exe;
	logic  src1_mem;
	logic  src1_wb;
	logic  src2_exe;
	logic  src2_mem;
	logic  src2_wb;
	logic  csr_exe;
	logic  csr_mem;
	word_t exe_val;
	word_t mem_val;
	word_t wb_val;

	// Source matches one stage unless it is x0
	function automatic logic reg_hit(reg_idx_t src, reg_idx_t dest, wb_kind_t kind);
		return (src == dest) && (src != ZERO_REG) && (kind != NO_WB);
	endfunction

	// Load data does not exist yet in execute
	assign exe_val = (exe_wb == WB_JAL) ? exe_pc_next : exe_alu_result;
	assign mem_val = wb_value(mem_wb, mem_alu_result, mem_mem_data, mem_pc_next);
	assign wb_val  = wb_value(wb_wb, wb_alu_result, wb_mem_data, wb_pc_next);

	// Youngest stage wins
	assign src1_exe = reg_hit(dec_src1, exe_dest, exe_wb);
	assign src1_mem = reg_hit(dec_src1, mem_dest, mem_wb) && !src1_exe;
	assign src1_wb  = reg_hit(dec_src1, wb_dest, wb_wb) && !src1_exe && !src1_mem;

	assign src2_exe = reg_hit(dec_src2, exe_dest, exe_wb);
	assign src2_mem = reg_hit(dec_src2, mem_dest, mem_wb) && !src2_exe;
	assign src2_wb  = reg_hit(dec_src2, wb_dest, wb_wb) && !src2_exe && !src2_mem;

	assign csr_exe = exe_is_csr && (dec_csr_addr == exe_csr_addr);
	assign csr_mem = mem_is_csr && (dec_csr_addr == mem_csr_addr) && !csr_exe;

	assign src1_fwd = src1_exe || src1_mem || src1_wb;
	assign src2_fwd = src2_exe || src2_mem || src2_wb;
	assign csr_fwd  = csr_exe || csr_mem;

	always_comb begin
		src1_fwd_data = FWD_POISON;
		if (src1_exe)
			src1_fwd_data = exe_val;
		else if (src1_mem)
			src1_fwd_data = mem_val;
		else if (src1_wb)
			src1_fwd_data = wb_val;

		src2_fwd_data = FWD_POISON;
		if (src2_exe)
			src2_fwd_data = exe_val;
		else if (src2_mem)
			src2_fwd_data = mem_val;
		else if (src2_wb)
			src2_fwd_data = wb_val;

		csr_fwd_data = FWD_POISON;
		if (csr_exe)
			csr_fwd_data = exe_alu_result; // New CSR value still in the ALU result
		else if (csr_mem)
			csr_fwd_data = mem_csr_result;
	end

	// Load in execute feeding decode
	assign stall = ((src1_exe || src2_exe) && (exe_wb == WB_MEM)) ? STALL : NO_STALL;

endmodule

// File: hw/vx_operand_latch.sv
`timescale 1ns/1ps

module vx_operand_latch (
	input  logic               clk,
	input  logic               rst,
	input  logic               stall,

	input  logic               src1_fwd,
	input  logic               src2_fwd,
	input  logic               csr_fwd,
	input  vx_pipe_pkg::word_t src1_fwd_data,
	input  vx_pipe_pkg::word_t src2_fwd_data,
	input  vx_pipe_pkg::word_t csr_fwd_data,

	input  vx_pipe_pkg::word_t rf_data1,
	input  vx_pipe_pkg::word_t rf_data2,
	input  vx_pipe_pkg::word_t csr_data,

	output logic               ex_valid,
	output vx_pipe_pkg::word_t ex_op1,
	output vx_pipe_pkg::word_t ex_op2,
	output vx_pipe_pkg::word_t ex_csr_val
);
	import vx_pipe_pkg::*;

	word_t op1_sel;
	word_t op2_sel;
	word_t csr_sel;

	// Forwarded value overrides the stored one
	assign op1_sel = src1_fwd ? src1_fwd_data : rf_data1;
	assign op2_sel = src2_fwd ? src2_fwd_data : rf_data2;
	assign csr_sel = csr_fwd  ? csr_fwd_data  : csr_data;

	// Stall turns the slot into a bubble
	always_ff @(posedge clk) begin
		if (rst)
			ex_valid <= 1'b0;
		else
			ex_valid <= (stall == NO_STALL);
	end

	always_ff @(posedge clk) begin
		if (stall == NO_STALL) begin // Held across a bubble
			ex_op1     <= op1_sel;
			ex_op2     <= op2_sel;
			ex_csr_val <= csr_sel;
		end
	end

endmodule

// File: hw/vx_operand_top.sv
`timescale 1ns/1ps

module vx_operand_top #(
	parameter int CSR_COUNT = 4
) (
	input  logic                   clk,
	input  logic                   rst,

	input  vx_pipe_pkg::reg_idx_t  dec_src1,
	input  vx_pipe_pkg::reg_idx_t  dec_src2,
	input  vx_csr_pkg::csr_addr_t  dec_csr_addr,

	input  vx_pipe_pkg::reg_idx_t  exe_dest,
	input  vx_pipe_pkg::wb_kind_t  exe_wb,
	input  vx_pipe_pkg::word_t     exe_alu_result,
	input  vx_pipe_pkg::word_t     exe_pc_next,
	input  logic                   exe_is_csr,
	input  vx_csr_pkg::csr_addr_t  exe_csr_addr,

	input  vx_pipe_pkg::reg_idx_t  mem_dest,
	input  vx_pipe_pkg::wb_kind_t  mem_wb,
	input  vx_pipe_pkg::word_t     mem_alu_result,
	input  vx_pipe_pkg::word_t     mem_mem_data,
	input  vx_pipe_pkg::word_t     mem_pc_next,
	input  logic                   mem_is_csr,
	input  vx_csr_pkg::csr_addr_t  mem_csr_addr,
	input  vx_pipe_pkg::word_t     mem_csr_result,

	input  vx_pipe_pkg::reg_idx_t  wb_dest,
	input  vx_pipe_pkg::wb_kind_t  wb_wb,
	input  vx_pipe_pkg::word_t     wb_alu_result,
	input  vx_pipe_pkg::word_t     wb_mem_data,
	input  vx_pipe_pkg::word_t     wb_pc_next,

	output logic                   ex_valid,
	output vx_pipe_pkg::word_t     ex_op1,
	output vx_pipe_pkg::word_t     ex_op2,
	output vx_pipe_pkg::word_t     ex_csr_val,
	output logic                   stall // Decode holds its inputs
);
	import vx_pipe_pkg::*;

	word_t rf_data1;
	word_t rf_data2;
	word_t csr_data;
	logic  src1_fwd;
	logic  src2_fwd;
	logic  csr_fwd;
	word_t src1_fwd_data;
	word_t src2_fwd_data;
	word_t csr_fwd_data;

	vx_regfile u_vx_regfile (
		.clk        (clk),
		.rst        (rst),
		.rd_idx1    (dec_src1),
		.rd_idx2    (dec_src2),
		.rd_data1   (rf_data1),
		.rd_data2   (rf_data2),
		.wr_idx     (wb_dest),
		.wr_kind    (wb_wb),
		.wr_alu     (wb_alu_result),
		.wr_mem     (wb_mem_data),
		.wr_pc_next (wb_pc_next)
	);

	vx_csr_file #(
		.CSR_COUNT (CSR_COUNT)
	) u_vx_csr_file (
		.clk     (clk),
		.rst     (rst),
		.rd_addr (dec_csr_addr),
		.rd_data (csr_data),
		.wr_en   (mem_is_csr),
		.wr_addr (mem_csr_addr),
		.wr_data (mem_csr_result)
	);

	vx_forwarding u_vx_forwarding (
		.dec_src1       (dec_src1),
		.dec_src2       (dec_src2),
		.dec_csr_addr   (dec_csr_addr),
		.exe_dest       (exe_dest),
		.exe_wb         (exe_wb),
		.exe_alu_result (exe_alu_result),
		.exe_pc_next    (exe_pc_next),
		.exe_is_csr     (exe_is_csr),
		.exe_csr_addr   (exe_csr_addr),
		.mem_dest       (mem_dest),
		.mem_wb         (mem_wb),
		.mem_alu_result (mem_alu_result),
		.mem_mem_data   (mem_mem_data),
		.mem_pc_next    (mem_pc_next),
		.mem_is_csr     (mem_is_csr),
		.mem_csr_addr   (mem_csr_addr),
		.mem_csr_result (mem_csr_result),
		.wb_dest        (wb_dest),
		.wb_wb          (wb_wb),
		.wb_alu_result  (wb_alu_result),
		.wb_mem_data    (wb_mem_data),
		.wb_pc_next     (wb_pc_next),
		.src1_fwd       (src1_fwd),
		.src2_fwd       (src2_fwd),
		.csr_fwd        (csr_fwd),
		.src1_fwd_data  (src1_fwd_data),
		.src2_fwd_data  (src2_fwd_data),
		.csr_fwd_data   (csr_fwd_data),
		.stall          (stall)
	);

	vx_operand_latch u_vx_operand_latch (
		.clk           (clk),
		.rst           (rst),
		.stall         (stall),
		.src1_fwd      (src1_fwd),
		.src2_fwd      (src2_fwd),
		.csr_fwd       (csr_fwd),
		.src1_fwd_data (src1_fwd_data),
		.src2_fwd_data (src2_fwd_data),
		.csr_fwd_data  (csr_fwd_data),
		.rf_data1      (rf_data1),
		.rf_data2      (rf_data2),
		.csr_data      (csr_data),
		.ex_valid      (ex_valid),
		.ex_op1        (ex_op1),
		.ex_op2        (ex_op2),
		.ex_csr_val    (ex_csr_val)
	);

endmodule

// File: dv/vx_operand_props.sv
`timescale 1ns/1ps

module vx_operand_props (
	input logic               clk,
	input logic               rst,
	input logic               stall,
	input logic               ex_valid,
	input vx_pipe_pkg::word_t ex_op1,
	input vx_pipe_pkg::word_t ex_op2,
	input vx_pipe_pkg::word_t ex_csr_val
);
	import vx_pipe_pkg::*;

	logic  load_q;
	word_t op1_q;
	word_t op2_q;
	word_t csr_q;

	// Expectations follow the decode slot into execute
	always_ff @(posedge clk) begin
		if (rst)
			load_q <= 1'b0;
		else
			load_q <= vx_operand_tb.exp_load;
	end

	always_ff @(posedge clk) begin
		op1_q <= vx_operand_tb.exp_op1;
		op2_q <= vx_operand_tb.exp_op2;
		csr_q <= vx_operand_tb.exp_csr;
	end

	a_reset_idle: assert property (@(posedge clk) rst |=> !ex_valid)
		else begin
			vx_operand_tb.assert_errors++;
			$error("ex_valid high in the first cycle after reset at t=%0t", $time);
		end

	a_stall_level: assert property (@(posedge clk) disable iff (rst)
		stall == vx_operand_tb.exp_stall)
		else begin
			vx_operand_tb.assert_errors++;
			$error("MISMATCH t=%0t stall expected %b actual %b", $time,
				vx_operand_tb.exp_stall, stall);
		end

	a_bubble: assert property (@(posedge clk) disable iff (rst) stall |=> !ex_valid)
		else begin
			vx_operand_tb.assert_errors++;
			$error("ex_valid high after a stall cycle at t=%0t", $time);
		end

	a_issue: assert property (@(posedge clk) disable iff (rst) !stall |=> ex_valid)
		else begin
			vx_operand_tb.assert_errors++;
			$error("ex_valid low after a decode without stall at t=%0t", $time);
		end

	a_op1: assert property (@(posedge clk) disable iff (rst) load_q |-> ex_op1 == op1_q)
		else begin
			vx_operand_tb.assert_errors++;
			$error("MISMATCH t=%0t ex_op1 expected %h actual %h", $time,
				$sampled(op1_q), $sampled(ex_op1));
		end

	a_op2: assert property (@(posedge clk) disable iff (rst) load_q |-> ex_op2 == op2_q)
		else begin
			vx_operand_tb.assert_errors++;
			$error("MISMATCH t=%0t ex_op2 expected %h actual %h", $time,
				$sampled(op2_q), $sampled(ex_op2));
		end

	a_csr: assert property (@(posedge clk) disable iff (rst) load_q |-> ex_csr_val == csr_q)
		else begin
			vx_operand_tb.assert_errors++;
			$error("MISMATCH t=%0t ex_csr_val expected %h actual %h", $time,
				$sampled(csr_q), $sampled(ex_csr_val));
		end

endmodule

// File: dv/vx_operand_tb.sv
`timescale 1ns/1ps

module vx_operand_tb;
	import vx_pipe_pkg::*;
	import vx_csr_pkg::*;

	localparam int CSR_COUNT   = 4;
	localparam int N_TESTS     = 6;
	localparam int TEST_CYCLES = 320; // Longest test is the random one
	localparam int MARGIN      = 50;
	localparam int WATCHDOG_NS = (N_TESTS * TEST_CYCLES + MARGIN) * 8;

	logic      clk;
	logic      rst;
	reg_idx_t  dec_src1;
	reg_idx_t  dec_src2;
	csr_addr_t dec_csr_addr;
	reg_idx_t  exe_dest;
	wb_kind_t  exe_wb;
	word_t     exe_alu_result;
	word_t     exe_pc_next;
	logic      exe_is_csr;
	csr_addr_t exe_csr_addr;
	reg_idx_t  mem_dest;
	wb_kind_t  mem_wb;
	word_t     mem_alu_result;
	word_t     mem_mem_data;
	word_t     mem_pc_next;
	logic      mem_is_csr;
	csr_addr_t mem_csr_addr;
	word_t     mem_csr_result;
	reg_idx_t  wb_dest;
	wb_kind_t  wb_wb;
	word_t     wb_alu_result;
	word_t     wb_mem_data;
	word_t     wb_pc_next;
	logic      ex_valid;
	word_t     ex_op1;
	word_t     ex_op2;
	word_t     ex_csr_val;
	logic      stall;

	// Read by the bound checker
	logic  exp_stall = 1'b0;
	logic  exp_load = 1'b0;
	word_t exp_op1 = '0;
	word_t exp_op2 = '0;
	word_t exp_csr = '0;
	int    assert_errors = 0;

	word_t shadow_rf [32];
	word_t shadow_csr [CSR_COUNT];
	int    tests_run = 0;
	int    tests_failed = 0;
	int    errors_before = 0;

	vx_operand_top #(
		.CSR_COUNT (CSR_COUNT)
	) u_vx_operand_top (.*);

	bind vx_operand_top vx_operand_props u_vx_operand_props (
		.clk        (clk),
		.rst        (rst),
		.stall      (stall),
		.ex_valid   (ex_valid),
		.ex_op1     (ex_op1),
		.ex_op2     (ex_op2),
		.ex_csr_val (ex_csr_val)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic word_t result_of(wb_kind_t kind, word_t alu, word_t mem, word_t pc);
		if (kind == WB_JAL)
			return pc;
		if (kind == WB_MEM)
			return mem;
		return alu;
	endfunction

	function automatic logic in_bank(csr_addr_t addr);
		return (int'(addr) >= int'(CSR_BASE)) && (int'(addr) < int'(CSR_BASE) + CSR_COUNT);
	endfunction

	// Oldest stage first, so younger matches overwrite it
	function automatic word_t expect_reg(reg_idx_t src);
		word_t v;
		if (src == 5'd0)
			return '0;
		v = shadow_rf[src];
		if (wb_wb != NO_WB && wb_dest == src)
			v = result_of(wb_wb, wb_alu_result, wb_mem_data, wb_pc_next);
		if (mem_wb != NO_WB && mem_dest == src)
			v = result_of(mem_wb, mem_alu_result, mem_mem_data, mem_pc_next);
		if (exe_wb != NO_WB && exe_dest == src)
			v = (exe_wb == WB_JAL) ? exe_pc_next : exe_alu_result;
		return v;
	endfunction

	function automatic word_t expect_csr(csr_addr_t addr);
		word_t v;
		v = '0;
		if (in_bank(addr))
			v = shadow_csr[int'(addr) - int'(CSR_BASE)];
		if (mem_is_csr && mem_csr_addr == addr)
			v = mem_csr_result;
		if (exe_is_csr && exe_csr_addr == addr)
			v = exe_alu_result;
		return v;
	endfunction

	function automatic logic expect_stall();
		logic hit1;
		logic hit2;
		hit1 = (dec_src1 != 5'd0) && (dec_src1 == exe_dest);
		hit2 = (dec_src2 != 5'd0) && (dec_src2 == exe_dest);
		return (exe_wb == WB_MEM) && (hit1 || hit2);
	endfunction

	// Publish expectations, update shadows, then cross one edge
	task automatic step();
		exp_stall = expect_stall();
		exp_load  = !exp_stall;
		exp_op1   = expect_reg(dec_src1);
		exp_op2   = expect_reg(dec_src2);
		exp_csr   = expect_csr(dec_csr_addr);
		if (wb_wb != NO_WB && wb_dest != 5'd0)
			shadow_rf[wb_dest] = result_of(wb_wb, wb_alu_result, wb_mem_data, wb_pc_next);
		if (mem_is_csr && in_bank(mem_csr_addr))
			shadow_csr[int'(mem_csr_addr) - int'(CSR_BASE)] = mem_csr_result;
		@(posedge clk);
		#1;
	endtask

	task automatic clear_inputs();
		dec_src1       = '0;
		dec_src2       = '0;
		dec_csr_addr   = '0;
		exe_dest       = '0;
		exe_wb         = NO_WB;
		exe_alu_result = '0;
		exe_pc_next    = '0;
		exe_is_csr     = 1'b0;
		exe_csr_addr   = '0;
		mem_dest       = '0;
		mem_wb         = NO_WB;
		mem_alu_result = '0;
		mem_mem_data   = '0;
		mem_pc_next    = '0;
		mem_is_csr     = 1'b0;
		mem_csr_addr   = '0;
		mem_csr_result = '0;
		wb_dest        = '0;
		wb_wb          = NO_WB;
		wb_alu_result  = '0;
		wb_mem_data    = '0;
		wb_pc_next     = '0;
	endtask

	task automatic end_test(string name);
		clear_inputs();
		step();
		step(); // Last checks land here
		tests_run++;
		if (assert_errors == errors_before) begin
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed, %0d assertion errors", name, assert_errors - errors_before);
		end
		errors_before = assert_errors;
	endtask

	task automatic test_issue();
		dec_src1     = 5'd1;
		dec_src2     = 5'd2;
		dec_csr_addr = CSR_BASE;
		step();
		end_test("issue");
	endtask

	task automatic test_priority();
		dec_src1       = 5'd3;
		dec_src2       = 5'd3;
		exe_dest       = 5'd3;
		exe_wb         = WB_ALU;
		exe_alu_result = 32'h1111_0001;
		exe_pc_next    = 32'h0000_1004;
		mem_dest       = 5'd3;
		mem_wb         = WB_ALU;
		mem_alu_result = 32'h2222_0002;
		mem_mem_data   = 32'h2222_00d0;
		mem_pc_next    = 32'h0000_2004;
		wb_dest        = 5'd3;
		wb_wb          = WB_ALU;
		wb_alu_result  = 32'h3333_0003;
		step(); // All three match
		exe_wb = NO_WB;
		mem_wb = WB_MEM;
		step();
		mem_wb = WB_JAL;
		step();
		exe_wb   = WB_JAL;
		dec_src2 = 5'd4;
		step();
		end_test("priority");
	endtask

	task automatic test_x0();
		exe_wb         = WB_ALU;
		exe_alu_result = 32'hffff_ffff;
		mem_wb         = WB_MEM;
		mem_mem_data   = 32'ha5a5_a5a5;
		wb_wb          = WB_ALU;
		wb_alu_result  = 32'h5a5a_5a5a; // Write to x0 dropped
		step();
		step();
		end_test("x0");
	endtask

	task automatic test_load_use();
		dec_src1       = 5'd5;
		dec_src2       = 5'd6;
		exe_dest       = 5'd5;
		exe_wb         = WB_MEM;
		exe_alu_result = 32'h0000_4000;
		step(); // Stall
		exe_wb       = NO_WB;
		mem_dest     = 5'd5;
		mem_wb       = WB_MEM;
		mem_mem_data = 32'hcafe_0005;
		step(); // Load now in memory
		exe_dest = 5'd6;
		exe_wb   = WB_MEM;
		step();
		end_test("load_use");
	endtask

	task automatic test_csr();
		dec_csr_addr   = CSR_BASE + 12'd1;
		mem_is_csr     = 1'b1;
		mem_csr_addr   = CSR_BASE + 12'd1;
		mem_csr_result = 32'h00c5_0001;
		step();
		exe_is_csr     = 1'b1;
		exe_csr_addr   = CSR_BASE + 12'd1;
		exe_alu_result = 32'h00c5_0002;
		mem_csr_result = 32'h00c5_0003;
		step(); // Execute beats memory
		exe_is_csr = 1'b0;
		mem_is_csr = 1'b0;
		step(); // Stored value
		mem_is_csr     = 1'b1;
		mem_csr_addr   = CSR_BASE + 12'd8;
		mem_csr_result = 32'hffff_0008;
		dec_csr_addr   = CSR_BASE - 12'd1;
		step();
		mem_is_csr   = 1'b0;
		dec_csr_addr = CSR_BASE + 12'd8;
		step();
		end_test("csr");
	endtask

	task automatic randomize_stages();
		exe_dest       = reg_idx_t'($urandom_range(0, 7));
		exe_wb         = wb_kind_t'(2'($urandom_range(0, 3)));
		exe_alu_result = $urandom;
		exe_pc_next    = $urandom;
		exe_is_csr     = 1'($urandom_range(0, 1));
		exe_csr_addr   = CSR_BASE - 12'd2 + 12'($urandom_range(0, 7));
		mem_dest       = reg_idx_t'($urandom_range(0, 7));
		mem_wb         = wb_kind_t'(2'($urandom_range(0, 3)));
		mem_alu_result = $urandom;
		mem_mem_data   = $urandom;
		mem_pc_next    = $urandom;
		mem_is_csr     = 1'($urandom_range(0, 1));
		mem_csr_addr   = CSR_BASE - 12'd2 + 12'($urandom_range(0, 7));
		mem_csr_result = $urandom;
		wb_dest        = reg_idx_t'($urandom_range(0, 7));
		wb_wb          = wb_kind_t'(2'($urandom_range(0, 3)));
		wb_alu_result  = $urandom;
		wb_mem_data    = $urandom;
		wb_pc_next     = $urandom;
	endtask

	task automatic test_random();
		repeat (300) begin
			if (!exp_stall) begin // Decode holds through a stall
				dec_src1     = reg_idx_t'($urandom_range(0, 7));
				dec_src2     = reg_idx_t'($urandom_range(0, 7));
				dec_csr_addr = CSR_BASE - 12'd2 + 12'($urandom_range(0, 7));
			end
			randomize_stages();
			step();
		end
		end_test("random");
	endtask

	initial begin
		void'($urandom(32'h76f1cab3));
		rst = 1'b1;
		clear_inputs();
		foreach (shadow_rf[i])
			shadow_rf[i] = '0;
		foreach (shadow_csr[i])
			shadow_csr[i] = '0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		test_issue();
		test_priority();
		test_x0();
		test_load_use();
		test_csr();
		test_random();
		$display("%0d tests, %0d failed, %0d assertion errors", tests_run, tests_failed,
			assert_errors);
		if (tests_failed == 0 && assert_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	initial begin
		#WATCHDOG_NS;
		$display("timeout: tests still running after %0d ns", WATCHDOG_NS);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: project.f
common/vx_pipe_pkg.sv
common/vx_csr_pkg.sv
hw/vx_regfile.sv
hw/vx_csr_file.sv
forwarding/vx_forwarding.sv
hw/vx_operand_latch.sv
hw/vx_operand_top.sv
dv/vx_operand_props.sv
dv/vx_operand_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the operand testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module vx_operand_tb -Mdir obj_dir -f project.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

# Keep running past the first assertion so every error is reported
out=$(./obj_dir/Vvx_operand_tb +verilator+error+limit+1000 2>&1)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
	exit 0
fi
exit 1
